/* project.f */
hdl/lsuPkg.sv
hdl/storeQueue.sv
hdl/loadStoreUnit.sv
hdl/dataMemory.sv
hdl/csrFile.sv
hdl/memSubsystem.sv
sim/memSubsystemTb.sv

/* sim/lsuTrace.txt */
# op addr data mask size sext tag sqn expData expFlags, every field in hex
# op: I idle, S store, C commit, B branch, L load, X squashed load; size 0 byte 1 half 2 word
S 00000020 a5c37e81 f 0 0 00 01 00000000 0
C 00000000 00000000 0 0 0 00 01 00000000 0
I 00000000 00000000 0 0 0 00 00 00000000 0
L 00000020 00000000 0 0 1 01 01 ffffff81 0
L 00000020 00000000 0 0 0 02 01 00000081 0
L 00000021 00000000 0 0 1 03 01 0000007e 0
L 00000022 00000000 0 0 1 04 01 ffffffc3 0
L 00000023 00000000 0 0 0 05 01 000000a5 0
L 00000020 00000000 0 1 1 06 01 00007e81 0
L 00000022 00000000 0 1 1 07 01 ffffa5c3 0
L 00000022 00000000 0 1 0 08 01 0000a5c3 0
L 00000020 00000000 0 2 0 09 01 a5c37e81 0
S 00000020 11223344 f 0 0 00 02 00000000 0
L 00000020 00000000 0 2 0 0a 01 a5c37e81 0
L 00000020 00000000 0 2 0 0b 02 11223344 0
S 00000020 0000beef 3 0 0 00 03 00000000 0
L 00000020 00000000 0 2 0 0c 03 1122beef 0
C 00000000 00000000 0 0 0 00 03 00000000 0
L 00000020 00000000 0 2 0 0d 03 1122beef 0
I 00000000 00000000 0 0 0 00 00 00000000 0
S 00000020 00abcd00 6 0 0 00 04 00000000 0
L 00000020 00000000 0 2 0 0e 04 11abcdef 0
L 00000022 00000000 0 1 0 0f 04 000011ab 0
L 00000021 00000000 0 0 1 10 04 ffffffcd 0
C 00000000 00000000 0 0 0 00 04 00000000 0
I 00000000 00000000 0 0 0 00 00 00000000 0
S ff000008 cafef00d f 0 0 00 05 00000000 0
C 00000000 00000000 0 0 0 00 05 00000000 0
I 00000000 00000000 0 0 0 00 00 00000000 0
L ff000008 00000000 0 2 0 11 05 cafef00d 0
L 00000008 00000000 0 2 0 12 05 00000000 0
L ff00000b 00000000 0 0 1 13 05 ffffffca 0
S 00000040 12345678 f 0 0 00 06 00000000 0
C 00000000 00000000 0 0 0 00 06 00000000 0
I 00000000 00000000 0 0 0 00 00 00000000 0
S 00000040 99999999 f 0 0 00 07 00000000 0
L 00000040 00000000 0 2 0 14 06 12345678 0
B 00000000 00000000 0 0 0 00 06 00000000 0
L 00000040 00000000 0 2 0 15 07 12345678 0
S 00000044 55555555 f 0 0 00 07 00000000 0
X 00000044 00000000 0 2 0 16 07 55555555 0
B 00000000 00000000 0 0 0 00 06 00000000 0
L 00000044 00000000 0 2 0 17 07 00000000 0
L 00000045 00000000 0 1 1 18 07 00000000 1
L 00000042 00000000 0 2 0 19 07 00000000 1

/* sim/memSubsystemTb.sv */
`timescale 1ns/10ps

module memSubsystemTb;
    import lsuPkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int MAX_LINES    = 256;

    logic             clk;
    logic             rst;
    logic             ldValid;
    logic [31:0]      ldAddr;
    LoadSize          ldSize;
    logic             ldSignExt;
    logic [TAG_W-1:0] ldTag;
    logic [SQN_W-1:0] ldSqN;
    logic             stValid;
    logic [31:0]      stAddr;
    logic [31:0]      stData;
    logic [3:0]       stMask;
    logic [SQN_W-1:0] stSqN;
    logic             commitValid;
    logic [SQN_W-1:0] commitSqN;
    logic             branchTaken;
    logic [SQN_W-1:0] branchSqN;
    logic             resValid;
    logic [31:0]      resData;
    logic [TAG_W-1:0] resTag;
    logic [SQN_W-1:0] resSqN;
    ResultFlags       resFlags;

    // One record per trace line.
    logic [7:0]       opArr      [MAX_LINES];
    logic [31:0]      addrArr    [MAX_LINES];
    logic [31:0]      dataArr    [MAX_LINES];
    logic [3:0]       maskArr    [MAX_LINES];
    logic [1:0]       sizeArr    [MAX_LINES];
    logic             sextArr    [MAX_LINES];
    logic [TAG_W-1:0] tagArr     [MAX_LINES];
    logic [SQN_W-1:0] sqnArr     [MAX_LINES];
    logic [31:0]      expArr     [MAX_LINES];
    logic             expFlagArr [MAX_LINES];

    int nLines     = 0;
    int errors     = 0;
    int testCount  = 0;
    int passCount  = 0;
    int cycleCount = 0;
    int cycleLimit = 1000;

    memSubsystem #(
        .SQ_DEPTH (4),
        .MEM_WORDS(256)
    ) u_memSubsystem (
        .clk        (clk),
        .rst        (rst),
        .ldValid    (ldValid),
        .ldAddr     (ldAddr),
        .ldSize     (ldSize),
        .ldSignExt  (ldSignExt),
        .ldTag      (ldTag),
        .ldSqN      (ldSqN),
        .stValid    (stValid),
        .stAddr     (stAddr),
        .stData     (stData),
        .stMask     (stMask),
        .stSqN      (stSqN),
        .commitValid(commitValid),
        .commitSqN  (commitSqN),
        .branchTaken(branchTaken),
        .branchSqN  (branchSqN),
        .resValid   (resValid),
        .resData    (resData),
        .resTag     (resTag),
        .resSqN     (resSqN),
        .resFlags   (resFlags)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout after %0d cycles, the trace did not finish", cycleCount);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic loadTrace();
        int          fd;
        int          code;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] m;
        logic [31:0] z;
        logic [31:0] e;
        logic [31:0] t;
        logic [31:0] q;
        logic [31:0] x;
        logic [31:0] f;
        fd = $fopen("sim/lsuTrace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file sim/lsuTrace.txt");
            errors++;
        end else begin
            while (!$feof(fd) && nLines < MAX_LINES) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h",
                                   op, a, d, m, z, e, t, q, x, f);
                    if (code == 10) begin
                        opArr[nLines]      = op;
                        addrArr[nLines]    = a;
                        dataArr[nLines]    = d;
                        maskArr[nLines]    = m[3:0];
                        sizeArr[nLines]    = z[1:0];
                        sextArr[nLines]    = e[0];
                        tagArr[nLines]     = t[TAG_W-1:0];
                        sqnArr[nLines]     = q[SQN_W-1:0];
                        expArr[nLines]     = x;
                        expFlagArr[nLines] = f[0];
                        nLines++;
                    end else begin
                        $display("malformed trace line: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic clearInputs();
        ldValid     = 1'b0;
        ldAddr      = '0;
        ldSize      = SIZE_BYTE;
        ldSignExt   = 1'b0;
        ldTag       = '0;
        ldSqN       = '0;
        stValid     = 1'b0;
        stAddr      = '0;
        stData      = '0;
        stMask      = '0;
        stSqN       = '0;
        commitValid = 1'b0;
        commitSqN   = '0;
        branchTaken = 1'b0;
        branchSqN   = '0;
    endtask

    task automatic applyLine(input int idx);
        clearInputs();
        case (opArr[idx])
            "L", "X": begin
                ldValid   = 1'b1;
                ldAddr    = addrArr[idx];
                ldSize    = LoadSize'(sizeArr[idx]);
                ldSignExt = sextArr[idx];
                ldTag     = tagArr[idx];
                ldSqN     = sqnArr[idx];
            end
            "S": begin
                stValid = 1'b1;
                stAddr  = addrArr[idx];
                stData  = dataArr[idx];
                stMask  = maskArr[idx];
                stSqN   = sqnArr[idx];
            end
            "C": begin
                commitValid = 1'b1;
                commitSqN   = sqnArr[idx];
            end
            "B": begin
                branchTaken = 1'b1;
                branchSqN   = sqnArr[idx];
            end
            default: begin
            end
        endcase
    endtask

    // Looks at the result slot that belongs to the trace line issued two cycles ago.
    task automatic checkSlot(input int idx);
        int bad;
        bad = 0;
        if (opArr[idx] == "L") begin
            testCount++;
            if (resValid !== 1'b1) begin
                $display("load tag %0d at %h produced no result", tagArr[idx], addrArr[idx]);
                bad++;
            end else begin
                if (resTag !== tagArr[idx]) begin
                    $display("mismatch resTag: got 0x%02h, expected 0x%02h",
                             resTag, tagArr[idx]);
                    bad++;
                end
                if (resSqN !== sqnArr[idx]) begin
                    $display("mismatch resSqN: got 0x%02h, expected 0x%02h",
                             resSqN, sqnArr[idx]);
                    bad++;
                end
                if (resFlags !== ResultFlags'(expFlagArr[idx])) begin
                    $display("mismatch resFlags: got 0x%0h, expected 0x%0h",
                             resFlags, expFlagArr[idx]);
                    bad++;
                end
                // A misaligned load carries no defined data.
                if (!expFlagArr[idx] && resData !== expArr[idx]) begin
                    $display("mismatch resData: got 0x%08h, expected 0x%08h",
                             resData, expArr[idx]);
                    bad++;
                end
            end
            $display("test %0d: load tag %0d at %h %s", testCount, tagArr[idx],
                     addrArr[idx], (bad == 0) ? "ok" : "failed");
        end else if (opArr[idx] == "X") begin
            testCount++;
            if (resValid === 1'b1) begin
                $display("load tag %0d at %h was not squashed by the branch",
                         tagArr[idx], addrArr[idx]);
                bad++;
            end
            $display("test %0d: squashed load tag %0d %s", testCount, tagArr[idx],
                     (bad == 0) ? "ok" : "failed");
        end else if (resValid === 1'b1) begin
            $display("a result with tag %0d appeared although no load was issued", resTag);
            bad++;
        end
        if (bad == 0 && (opArr[idx] == "L" || opArr[idx] == "X")) begin
            passCount++;
        end
        errors += bad;
    endtask

    initial begin
        rst = 1'b1;
        clearInputs();
        loadTrace();
        // Reset, one cycle per trace line and some slack for the pipeline.
        cycleLimit = RESET_CYCLES + nLines + 20;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < nLines + 2; i++) begin
            @(negedge clk);
            if (i >= 2) begin
                checkSlot(i - 2);
            end
            if (i < nLines) begin
                applyLine(i);
            end else begin
                clearInputs();
            end
        end
        $display("tests %0d, passed %0d, errors %0d", testCount, passCount, errors);
        if (errors == 0 && testCount > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/memSubsystem.sv */
`timescale 1ns/10ps

module memSubsystem #(
    parameter int SQ_DEPTH  = 4,
    parameter int MEM_WORDS = 256
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ldValid,
    input  logic [31:0]              ldAddr,
    input  lsuPkg::LoadSize          ldSize,
    input  logic                     ldSignExt,
    input  logic [lsuPkg::TAG_W-1:0] ldTag,
    input  logic [lsuPkg::SQN_W-1:0] ldSqN,
    input  logic                     stValid,
    input  logic [31:0]              stAddr,
    input  logic [31:0]              stData,
    input  logic [3:0]               stMask,
    input  logic [lsuPkg::SQN_W-1:0] stSqN,
    input  logic                     commitValid,
    input  logic [lsuPkg::SQN_W-1:0] commitSqN,
    input  logic                     branchTaken,
    input  logic [lsuPkg::SQN_W-1:0] branchSqN,
    output logic                     resValid,
    output logic [31:0]              resData,
    output logic [lsuPkg::TAG_W-1:0] resTag,
    output logic [lsuPkg::SQN_W-1:0] resSqN,
    output lsuPkg::ResultFlags       resFlags
);
    logic [3:0]  fwdMask;
    logic [31:0] fwdData;
    logic        drainValid;
    logic [31:0] drainAddr;
    logic [31:0] drainData;
    logic [3:0]  drainMask;
    logic        memReadEn;
    logic [29:0] memReadAddr;
    logic [31:0] memReadData;
    logic [31:0] csrReadData;
    logic        memWriteEn;
    logic        csrWriteEn;
    logic [29:0] writeAddr;
    logic [31:0] writeData;
    logic [3:0]  writeMask;

    storeQueue #(
        .SQ_DEPTH(SQ_DEPTH)
    ) u_storeQueue (
        .clk        (clk),
        .rst        (rst),
        .stValid    (stValid),
        .stAddr     (stAddr),
        .stData     (stData),
        .stMask     (stMask),
        .stSqN      (stSqN),
        .commitValid(commitValid),
        .commitSqN  (commitSqN),
        .branchTaken(branchTaken),
        .branchSqN  (branchSqN),
        .lookupAddr (ldAddr),
        .lookupSqN  (ldSqN),
        .fwdMask    (fwdMask),
        .fwdData    (fwdData),
        .drainValid (drainValid),
        .drainAddr  (drainAddr),
        .drainData  (drainData),
        .drainMask  (drainMask)
    );

    loadStoreUnit u_loadStoreUnit (
        .clk        (clk),
        .rst        (rst),
        .branchTaken(branchTaken),
        .branchSqN  (branchSqN),
        .ldValid    (ldValid),
        .ldAddr     (ldAddr),
        .ldSize     (ldSize),
        .ldSignExt  (ldSignExt),
        .ldTag      (ldTag),
        .ldSqN      (ldSqN),
        .fwdMask    (fwdMask),
        .fwdData    (fwdData),
        .drainValid (drainValid),
        .drainAddr  (drainAddr),
        .drainData  (drainData),
        .drainMask  (drainMask),
        .memReadEn  (memReadEn),
        .memReadAddr(memReadAddr),
        .memReadData(memReadData),
        .csrReadData(csrReadData),
        .memWriteEn (memWriteEn),
        .csrWriteEn (csrWriteEn),
        .writeAddr  (writeAddr),
        .writeData  (writeData),
        .writeMask  (writeMask),
        .resValid   (resValid),
        .resData    (resData),
        .resTag     (resTag),
        .resSqN     (resSqN),
        .resFlags   (resFlags)
    );

    dataMemory #(
        .MEM_WORDS(MEM_WORDS)
    ) u_dataMemory (
        .clk      (clk),
        .readEn   (memReadEn),
        .readAddr (memReadAddr),
        .readData (memReadData),
        .writeEn  (memWriteEn),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .writeMask(writeMask)
    );

    csrFile u_csrFile (
        .clk      (clk),
        .rst      (rst),
        .readAddr (memReadAddr),
        .readData (csrReadData),
        .writeEn  (csrWriteEn),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .writeMask(writeMask)
    );

endmodule

/* hdl/csrFile.sv */
`timescale 1ns/10ps

module csrFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [29:0] readAddr,
    output logic [31:0] readData,
    input  logic        writeEn,
    input  logic [29:0] writeAddr,
    input  logic [31:0] writeData,
    input  logic [3:0]  writeMask
);
    logic [31:0] csrRegs [4];
    logic [1:0]  readSelReg;

    // Word address bits 1:0 are byte address bits 3:2.
    always_ff @(posedge clk) begin
        readSelReg <= readAddr[1:0];
        readData   <= csrRegs[readSelReg];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                csrRegs[i] <= '0;
            end
        end else if (!writeEn) begin
            for (int b = 0; b < 4; b++) begin
                if (writeMask[b]) begin
                    csrRegs[writeAddr[1:0]][8*b +: 8] <= writeData[8*b +: 8];
                end
            end
        end
    end

endmodule

/* hdl/dataMemory.sv */
`timescale 1ns/10ps

module dataMemory #(
    parameter int MEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        readEn,
    input  logic [29:0] readAddr,
    output logic [31:0] readData,
    input  logic        writeEn,
    input  logic [29:0] writeAddr,
    input  logic [31:0] writeData,
    input  logic [3:0]  writeMask
);
    localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [31:0]   mem [MEM_WORDS] = '{default: '0};
    logic [AW-1:0] readAddrReg;

    // The array is read in the second cycle, so a write in that cycle is not seen.
    always_ff @(posedge clk) begin
        if (!readEn) begin
            readAddrReg <= readAddr[AW-1:0];
        end
        readData <= mem[readAddrReg];
    end

    always_ff @(posedge clk) begin
        if (!writeEn) begin
            for (int b = 0; b < 4; b++) begin
                if (writeMask[b]) begin
                    mem[writeAddr[AW-1:0]][8*b +: 8] <= writeData[8*b +: 8];
                end
            end
        end
    end

endmodule

/* hdl/loadStoreUnit.sv */
`timescale 1ns/10ps

module loadStoreUnit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     branchTaken,
    input  logic [lsuPkg::SQN_W-1:0] branchSqN,
    input  logic                     ldValid,
    input  logic [31:0]              ldAddr,
    input  lsuPkg::LoadSize          ldSize,
    input  logic                     ldSignExt,
    input  logic [lsuPkg::TAG_W-1:0] ldTag,
    input  logic [lsuPkg::SQN_W-1:0] ldSqN,
    input  logic [3:0]               fwdMask,
    input  logic [31:0]              fwdData,
    input  logic                     drainValid,
    input  logic [31:0]              drainAddr,
    input  logic [31:0]              drainData,
    input  logic [3:0]               drainMask,
    output logic                     memReadEn,
    output logic [29:0]              memReadAddr,
    input  logic [31:0]              memReadData,
    input  logic [31:0]              csrReadData,
    output logic                     memWriteEn,
    output logic                     csrWriteEn,
    output logic [29:0]              writeAddr,
    output logic [31:0]              writeData,
    output logic [3:0]               writeMask,
    output logic                     resValid,
    output logic [31:0]              resData,
    output logic [lsuPkg::TAG_W-1:0] resTag,
    output logic [lsuPkg::SQN_W-1:0] resSqN,
    output lsuPkg::ResultFlags       resFlags
);
    import lsuPkg::*;

    logic ldKeep;
    logic s0Keep;
    logic ldMisaligned;
    logic drainToCsr;

    logic             s0Valid;
    logic [1:0]       s0Offset;
    LoadSize          s0Size;
    logic             s0SignExt;
    logic [TAG_W-1:0] s0Tag;
    logic [SQN_W-1:0] s0SqN;
    logic             s0Except;
    logic             s0IsCsr;
    logic [3:0]       s0FwdMask;
    logic [31:0]      s0FwdData;

    logic             s1Valid;
    logic [1:0]       s1Offset;
    LoadSize          s1Size;
    logic             s1SignExt;
    logic [TAG_W-1:0] s1Tag;
    logic [SQN_W-1:0] s1SqN;
    logic             s1Except;
    logic             s1IsCsr;
    logic [3:0]       s1FwdMask;
    logic [31:0]      s1FwdData;

    logic [31:0] merged;
    logic [7:0]  selByte;
    logic [15:0] selHalf;

    assign ldKeep = ldValid && (!branchTaken || notYounger(ldSqN, branchSqN));
    assign s0Keep = s0Valid && (!branchTaken || notYounger(s0SqN, branchSqN));

    // The read goes out in the load cycle, so data returns when the load is in stage 1.
    assign memReadEn   = !ldKeep;
    assign memReadAddr = ldAddr[31:2];

    assign drainToCsr = drainAddr[31:24] == CSR_PAGE;
    assign memWriteEn = !(drainValid && !drainToCsr);
    assign csrWriteEn = !(drainValid && drainToCsr);
    assign writeAddr  = drainAddr[31:2];
    assign writeData  = drainData;
    assign writeMask  = drainMask;

    always_comb begin
        case (ldSize)
            SIZE_HALF: ldMisaligned = ldAddr[0];
            SIZE_WORD: ldMisaligned = ldAddr[1:0] != 2'b00;
            default:   ldMisaligned = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s0Valid <= 1'b0;
            s1Valid <= 1'b0;
        end else begin
            s0Valid <= ldKeep;
            s1Valid <= s0Keep;
        end
    end

    always_ff @(posedge clk) begin
        if (ldKeep) begin
            s0Offset  <= ldAddr[1:0];
            s0Size    <= ldSize;
            s0SignExt <= ldSignExt;
            s0Tag     <= ldTag;
            s0SqN     <= ldSqN;
            s0Except  <= ldMisaligned;
            s0IsCsr   <= ldAddr[31:24] == CSR_PAGE;
            s0FwdMask <= fwdMask;
            s0FwdData <= fwdData;
        end
        if (s0Keep) begin
            s1Offset  <= s0Offset;
            s1Size    <= s0Size;
            s1SignExt <= s0SignExt;
            s1Tag     <= s0Tag;
            s1SqN     <= s0SqN;
            s1Except  <= s0Except;
            s1IsCsr   <= s0IsCsr;
            s1FwdMask <= s0FwdMask;
            s1FwdData <= s0FwdData;
        end
    end

    // Forwarded store bytes take priority over what the memory returned.
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (s1FwdMask[b]) begin
                merged[8*b +: 8] = s1FwdData[8*b +: 8];
            end else if (s1IsCsr) begin
                merged[8*b +: 8] = csrReadData[8*b +: 8];
            end else begin
                merged[8*b +: 8] = memReadData[8*b +: 8];
            end
        end
    end

    always_comb begin
        selByte = merged[{s1Offset, 3'b000} +: 8];
        selHalf = s1Offset[1] ? merged[31:16] : merged[15:0];
        case (s1Size)
            SIZE_BYTE: resData = {{24{s1SignExt & selByte[7]}}, selByte};
            SIZE_HALF: resData = {{16{s1SignExt & selHalf[15]}}, selHalf};
            default:   resData = merged;
        endcase
    end

    assign resValid = s1Valid;
    assign resTag   = s1Tag;
    assign resSqN   = s1SqN;
    assign resFlags = s1Except ? FLAGS_EXCEPT : FLAGS_NONE;

    // A drained store goes to exactly one target.
    assert property (@(posedge clk) disable iff (rst) memWriteEn || csrWriteEn)
        else $error("memory and CSR write enables are both active");

    // Every result has passed through stage 0 one cycle earlier.
    assert property (@(posedge clk) disable iff (rst) resValid |-> $past(s0Valid))
        else $error("load result without a preceding stage 0 entry");

endmodule

/* hdl/storeQueue.sv */
`timescale 1ns/10ps

module storeQueue #(
    parameter int SQ_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stValid,
    input  logic [31:0]              stAddr,
    input  logic [31:0]              stData,
    input  logic [3:0]               stMask,
    input  logic [lsuPkg::SQN_W-1:0] stSqN,
    input  logic                     commitValid,
    input  logic [lsuPkg::SQN_W-1:0] commitSqN,
    input  logic                     branchTaken,
    input  logic [lsuPkg::SQN_W-1:0] branchSqN,
    input  logic [31:0]              lookupAddr,
    input  logic [lsuPkg::SQN_W-1:0] lookupSqN,
    output logic [3:0]               fwdMask,
    output logic [31:0]              fwdData,
    output logic                     drainValid,
    output logic [31:0]              drainAddr,
    output logic [31:0]              drainData,
    output logic [3:0]               drainMask
);
    import lsuPkg::*;

    localparam int PTR_W = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(SQ_DEPTH + 1);

    logic [31:0]         entAddr [SQ_DEPTH];
    logic [31:0]         entData [SQ_DEPTH];
    logic [3:0]          entMask [SQ_DEPTH];
    logic [SQN_W-1:0]    entSqN [SQ_DEPTH];
    logic [SQ_DEPTH-1:0] entValid;
    logic [SQ_DEPTH-1:0] entCommitted;

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] insIdx;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] keepCount;
    logic [CNT_W-1:0] baseCount;
    logic             stEnter;
    logic             full;

    function automatic logic [PTR_W-1:0] wrapIdx(input logic [PTR_W-1:0] base, input int off);
        int sum;
        sum = int'(base) + off;
        return PTR_W'(sum % SQ_DEPTH);
    endfunction

    assign full    = count == CNT_W'(SQ_DEPTH);
    assign stEnter = stValid && (!branchTaken || notYounger(stSqN, branchSqN));

    // Entries are in age order from the head, so the survivors of a branch form a prefix.
    always_comb begin
        keepCount = '0;
        for (int k = 0; k < SQ_DEPTH; k++) begin
            if (k < count && (entCommitted[wrapIdx(head, k)] ||
                              notYounger(entSqN[wrapIdx(head, k)], branchSqN))) begin
                keepCount = CNT_W'(k + 1);
            end
        end
    end

    assign baseCount = branchTaken ? keepCount : count;
    assign insIdx    = branchTaken ? wrapIdx(head, int'(keepCount)) : tail;

    assign drainValid = entValid[head] && entCommitted[head];
    assign drainAddr  = entAddr[head];
    assign drainData  = entData[head];
    assign drainMask  = entMask[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            entValid     <= '0;
            entCommitted <= '0;
        end else begin
            if (commitValid) begin
                for (int i = 0; i < SQ_DEPTH; i++) begin
                    if (entValid[i] && notYounger(entSqN[i], commitSqN)) begin
                        entCommitted[i] <= 1'b1;
                    end
                end
            end
            if (branchTaken) begin
                for (int k = 0; k < SQ_DEPTH; k++) begin
                    if (k >= keepCount) begin
                        entValid[wrapIdx(head, k)] <= 1'b0;
                    end
                end
            end
            if (drainValid) begin
                entValid[head]     <= 1'b0;
                entCommitted[head] <= 1'b0;
                head               <= wrapIdx(head, 1);
            end
            if (stEnter) begin
                entValid[insIdx]     <= 1'b1;
                entCommitted[insIdx] <= 1'b0;
            end
            tail  <= wrapIdx(insIdx, stEnter ? 1 : 0);
            count <= baseCount + CNT_W'(stEnter) - CNT_W'(drainValid);
        end
    end

    always_ff @(posedge clk) begin
        if (stEnter) begin
            entAddr[insIdx] <= stAddr;
            entData[insIdx] <= stData;
            entMask[insIdx] <= stMask;
            entSqN[insIdx]  <= stSqN;
        end
    end

    // Walk from oldest to youngest so the youngest older store wins each byte.
    always_comb begin
        fwdMask = '0;
        fwdData = '0;
        for (int k = 0; k < SQ_DEPTH; k++) begin
            if (entValid[wrapIdx(head, k)] &&
                entAddr[wrapIdx(head, k)][31:2] == lookupAddr[31:2] &&
                notYounger(entSqN[wrapIdx(head, k)], lookupSqN)) begin
                for (int b = 0; b < 4; b++) begin
                    if (entMask[wrapIdx(head, k)][b]) begin
                        fwdMask[b]       = 1'b1;
                        fwdData[8*b +: 8] = entData[wrapIdx(head, k)][8*b +: 8];
                    end
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) stValid |-> !full)
        else $error("store arrived while the store queue is full");

endmodule

/* hdl/lsuPkg.sv */
package lsuPkg;

    localparam int SQN_W = 6;
    localparam int TAG_W = 6;

    // Top address byte of the control register page.
    localparam logic [7:0] CSR_PAGE = 8'hFF;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } LoadSize;

    typedef enum logic {
        FLAGS_NONE   = 1'b0,
        FLAGS_EXCEPT = 1'b1
    } ResultFlags;

    // True when sqN is the same age as refSqN or older.
    // Sequence numbers wrap around, so the sign of the difference decides.
    function automatic logic notYounger(
        input logic [SQN_W-1:0] sqN,
        input logic [SQN_W-1:0] refSqN
    );
        logic signed [SQN_W-1:0] diff;
        diff = sqN - refSqN;
        return diff <= 0;
    endfunction

endpackage
